// File: rtl/gpu_pkg.sv
`default_nettype none

package gpu_pkg;

        //////////////////////////////////////////////////
        // widths and sizes
        //////////////////////////////////////////////////
        localparam int ADDR_W     = 32;
        localparam int DATA_W     = 32;
        localparam int LEN_W      = 16;
        localparam int FIFO_DEPTH = 8;
        localparam int WORD_BYTES = 4;

        // host register map, byte offsets
        typedef enum logic [7:0] {
                REG_SRC    = 8'h00,
                REG_DST    = 8'h04,
                REG_LEN    = 8'h08,
                REG_CTRL   = 8'h0C,
                REG_STATUS = 8'h10
        } reg_addr_e;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_RUN,
                ST_DONE
        } copy_state_e;

        //////////////////////////////////////////////////
        // port payloads
        //////////////////////////////////////////////////
        typedef struct packed {
                logic              wr;
                logic [7:0]        addr;
                logic [DATA_W-1:0] wdata;
        } reg_req_t;

        // base address and word count
        typedef struct packed {
                logic [ADDR_W-1:0] addr;
                logic [LEN_W-1:0]  len;
        } dma_cmd_t;

        typedef struct packed {
                logic [ADDR_W-1:0] addr;
        } mem_rd_req_t;

        typedef struct packed {
                logic [ADDR_W-1:0] addr;
                logic [DATA_W-1:0] data;
        } mem_wr_req_t;

endpackage

`default_nettype wire

// File: rtl/gpu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_regs
        import gpu_pkg::*;
(
        input  wire               i_wire_clock,
        input  wire               i_rst_n,
        // host port
        input  wire               i_reg_valid,
        input  wire reg_req_t     i_reg_req,
        output logic              o_reg_rsp_valid,
        output logic [DATA_W-1:0] o_reg_rdata,
        // sequencer side
        input  wire               i_busy,
        input  wire               i_done,
        output logic              o_start,
        output dma_cmd_t          o_src_cmd,
        output dma_cmd_t          o_dst_cmd
);

        logic [ADDR_W-1:0] src_q;
        logic [ADDR_W-1:0] dst_q;
        logic [LEN_W-1:0]  len_q;
        logic              wr_en;
        logic              rd_en;
        reg_addr_e         req_addr;
        logic [DATA_W-1:0] status;
        logic [DATA_W-1:0] rd_mux;

        assign wr_en    = i_reg_valid && i_reg_req.wr;
        assign rd_en    = i_reg_valid && !i_reg_req.wr;
        assign req_addr = reg_addr_e'(i_reg_req.addr);

        // start still in flight to the sequencer reads as busy
        assign status = {{(DATA_W-2){1'b0}}, i_done && !o_start, i_busy || o_start};

        //////////////////////////////////////////////////
        // register writes and start command
        //////////////////////////////////////////////////
        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        src_q           <= '0;
                        dst_q           <= '0;
                        len_q           <= '0;
                        o_start         <= 1'b0;
                        o_reg_rsp_valid <= 1'b0;
                end else begin
                        o_start         <= wr_en && (req_addr == REG_CTRL) && i_reg_req.wdata[0];
                        o_reg_rsp_valid <= rd_en;
                        if (wr_en) begin
                                case (req_addr)
                                        REG_SRC: src_q <= i_reg_req.wdata[ADDR_W-1:0];
                                        REG_DST: dst_q <= i_reg_req.wdata[ADDR_W-1:0];
                                        REG_LEN: len_q <= i_reg_req.wdata[LEN_W-1:0];
                                        default: ;
                                endcase
                        end
                end
        end

        //////////////////////////////////////////////////
        // readback, one cycle latency
        //////////////////////////////////////////////////
        always_comb begin
                case (req_addr)
                        REG_SRC:    rd_mux = src_q;
                        REG_DST:    rd_mux = dst_q;
                        REG_LEN:    rd_mux = DATA_W'(len_q);
                        REG_STATUS: rd_mux = status;
                        default:    rd_mux = '0;
                endcase
        end

        always_ff @(posedge i_wire_clock) begin
                if (rd_en) begin
                        o_reg_rdata <= rd_mux;
                end
        end

        assign o_src_cmd = '{addr: src_q, len: len_q};
        assign o_dst_cmd = '{addr: dst_q, len: len_q};

endmodule

`default_nettype wire

// File: rtl/gpu_memcpy.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_memcpy
        import gpu_pkg::*;
(
        input  wire      i_wire_clock,
        input  wire      i_rst_n,
        // from register file
        input  wire      i_start,
        input  wire      dma_cmd_t i_src_cmd,
        input  wire      dma_cmd_t i_dst_cmd,
        // reader and writer control
        input  wire      i_wr_done,
        output logic     o_rd_go,
        output logic     o_wr_go,
        output dma_cmd_t o_rd_cmd,
        output dma_cmd_t o_wr_cmd,
        // status
        output logic     o_busy,
        output logic     o_done
);

        copy_state_e state_q;
        logic        go_q;
        logic        can_start;
        dma_cmd_t    src_q;
        dma_cmd_t    dst_q;

        // starts only count from idle or after a finished copy
        assign can_start = i_start && (state_q == ST_IDLE || state_q == ST_DONE);

        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        state_q <= ST_IDLE;
                        go_q    <= 1'b0;
                end else begin
                        go_q <= 1'b0;
                        case (state_q)
                                ST_IDLE, ST_DONE: begin
                                        if (can_start && i_src_cmd.len == '0) begin
                                                state_q <= ST_DONE;
                                        end else if (can_start) begin
                                                state_q <= ST_RUN;
                                                go_q    <= 1'b1;
                                        end
                                end
                                ST_RUN: begin
                                        // last write accepted by memory
                                        if (i_wr_done) begin
                                                state_q <= ST_DONE;
                                        end
                                end
                                default: state_q <= ST_IDLE;
                        endcase
                end
        end

        // commands held for the whole copy
        always_ff @(posedge i_wire_clock) begin
                if (can_start) begin
                        src_q <= i_src_cmd;
                        dst_q <= i_dst_cmd;
                end
        end

        assign o_rd_go  = go_q;
        assign o_wr_go  = go_q;
        assign o_rd_cmd = src_q;
        assign o_wr_cmd = dst_q;
        assign o_busy   = (state_q == ST_RUN);
        assign o_done   = (state_q == ST_DONE);

endmodule

`default_nettype wire

// File: rtl/gpu_dma_reader.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_dma_reader
        import gpu_pkg::*;
(
        input  wire               i_wire_clock,
        input  wire               i_rst_n,
        input  wire               i_go,
        input  wire dma_cmd_t     i_cmd,
        // read request channel
        output logic              o_rd_valid,
        output mem_rd_req_t       o_rd_req,
        input  wire               i_rd_ready,
        // read response channel
        input  wire [DATA_W-1:0]  i_rd_data,
        input  wire               i_rd_resp_valid,
        output logic              o_rd_resp_ready,
        // fifo push side
        input  wire               i_fifo_full,
        output logic              o_push,
        output logic [DATA_W-1:0] o_push_data
);

        logic [ADDR_W-1:0] addr_q;
        logic [LEN_W-1:0]  left_q;
        logic              req_fire;

        assign req_fire = o_rd_valid && i_rd_ready;

        //////////////////////////////////////////////////
        // request issue
        //////////////////////////////////////////////////
        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_rd_valid <= 1'b0;
                        left_q     <= '0;
                end else if (i_go) begin
                        o_rd_valid <= (i_cmd.len != '0);
                        left_q     <= i_cmd.len;
                end else if (req_fire) begin
                        // drop valid after the last accepted request
                        o_rd_valid <= (left_q != LEN_W'(1));
                        left_q     <= left_q - 1'b1;
                end
        end

        always_ff @(posedge i_wire_clock) begin
                if (i_go) begin
                        addr_q <= i_cmd.addr;
                end else if (req_fire) begin
                        addr_q <= addr_q + ADDR_W'(WORD_BYTES);
                end
        end

        assign o_rd_req = '{addr: addr_q};

        //////////////////////////////////////////////////
        // responses into the fifo
        //////////////////////////////////////////////////
        // memory holds a response while the fifo is full
        assign o_rd_resp_ready = !i_fifo_full;
        assign o_push          = i_rd_resp_valid && !i_fifo_full;
        assign o_push_data     = i_rd_data;

endmodule

`default_nettype wire

// File: rtl/gpu_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_fifo
        import gpu_pkg::*;
#(
        parameter int DEPTH = FIFO_DEPTH
) (
        input  wire               i_wire_clock,
        input  wire               i_rst_n,
        input  wire               i_push,
        input  wire [DATA_W-1:0]  i_push_data,
        input  wire               i_pop,
        output logic              o_full,
        output logic              o_pop_valid,
        output logic [DATA_W-1:0] o_pop_data
);

        localparam int PTR_W = $clog2(DEPTH);

        logic [DATA_W-1:0] mem [DEPTH];
        logic [PTR_W-1:0]  wr_ptr_q;
        logic [PTR_W-1:0]  rd_ptr_q;
        logic [PTR_W:0]    count_q;

        function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
                return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        always_ff @(posedge i_wire_clock) begin
                if (i_push) begin
                        mem[wr_ptr_q] <= i_push_data;
                end
        end

        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (i_push) wr_ptr_q <= next_ptr(wr_ptr_q);
                        if (i_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
                        case ({i_push, i_pop})
                                2'b10:   count_q <= count_q + 1'b1;
                                2'b01:   count_q <= count_q - 1'b1;
                                default: ;
                        endcase
                end
        end

        // head word visible as soon as it is stored
        assign o_full      = (count_q == (PTR_W + 1)'(DEPTH));
        assign o_pop_valid = (count_q != '0);
        assign o_pop_data  = mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: rtl/gpu_dma_writer.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_dma_writer
        import gpu_pkg::*;
(
        input  wire              i_wire_clock,
        input  wire              i_rst_n,
        input  wire              i_go,
        input  wire dma_cmd_t    i_cmd,
        // fifo pop side
        input  wire              i_pop_valid,
        input  wire [DATA_W-1:0] i_pop_data,
        output logic             o_pop,
        // write request channel
        output logic             o_wr_valid,
        output mem_wr_req_t      o_wr_req,
        input  wire              i_wr_ready,
        output logic             o_done
);

        logic [ADDR_W-1:0] addr_q;
        logic [LEN_W-1:0]  left_q;
        logic              wr_fire;

        // fifo head stays put until popped, so valid and payload hold
        assign o_wr_valid = (left_q != '0) && i_pop_valid;
        assign wr_fire    = o_wr_valid && i_wr_ready;
        assign o_pop      = wr_fire;
        assign o_wr_req   = '{addr: addr_q, data: i_pop_data};

        //////////////////////////////////////////////////
        // word count and completion
        //////////////////////////////////////////////////
        always_ff @(posedge i_wire_clock or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        left_q <= '0;
                        o_done <= 1'b0;
                end else begin
                        o_done <= wr_fire && (left_q == LEN_W'(1));
                        if (i_go) begin
                                left_q <= i_cmd.len;
                        end else if (wr_fire) begin
                                left_q <= left_q - 1'b1;
                        end
                end
        end

        // destination address walk
        always_ff @(posedge i_wire_clock) begin
                if (i_go) begin
                        addr_q <= i_cmd.addr;
                end else if (wr_fire) begin
                        addr_q <= addr_q + ADDR_W'(WORD_BYTES);
                end
        end

endmodule

`default_nettype wire

// File: rtl/gpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_top
        import gpu_pkg::*;
(
        input  wire               i_wire_clock,
        input  wire               i_rst_n,
        // host register port
        input  wire               i_reg_valid,
        input  wire reg_req_t     i_reg_req,
        output logic              o_reg_rsp_valid,
        output logic [DATA_W-1:0] o_reg_rdata,
        // memory read port
        output logic              o_rd_valid,
        output mem_rd_req_t       o_rd_req,
        input  wire               i_rd_ready,
        input  wire [DATA_W-1:0]  i_rd_data,
        input  wire               i_rd_resp_valid,
        output logic              o_rd_resp_ready,
        // memory write port
        output logic              o_wr_valid,
        output mem_wr_req_t       o_wr_req,
        input  wire               i_wr_ready
);

        logic              start_pulse;
        dma_cmd_t          src_cmd;
        dma_cmd_t          dst_cmd;
        logic              busy;
        logic              done;
        logic              rd_go;
        logic              wr_go;
        dma_cmd_t          rd_cmd;
        dma_cmd_t          wr_cmd;
        logic              wr_done;
        logic              fifo_full;
        logic              push;
        logic [DATA_W-1:0] push_data;
        logic              pop;
        logic              pop_valid;
        logic [DATA_W-1:0] pop_data;

        //////////////////////////////////////////////////
        // control path
        //////////////////////////////////////////////////
        gpu_regs regs_i (
                .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
                .i_reg_valid(i_reg_valid), .i_reg_req(i_reg_req),
                .o_reg_rsp_valid(o_reg_rsp_valid), .o_reg_rdata(o_reg_rdata),
                .i_busy(busy), .i_done(done), .o_start(start_pulse),
                .o_src_cmd(src_cmd), .o_dst_cmd(dst_cmd)
        );

        gpu_memcpy memcpy_i (
                .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
                .i_start(start_pulse), .i_src_cmd(src_cmd), .i_dst_cmd(dst_cmd),
                .i_wr_done(wr_done), .o_rd_go(rd_go), .o_wr_go(wr_go),
                .o_rd_cmd(rd_cmd), .o_wr_cmd(wr_cmd), .o_busy(busy), .o_done(done)
        );

        //////////////////////////////////////////////////
        // data path, reader to fifo to writer
        //////////////////////////////////////////////////
        gpu_dma_reader reader_i (
                .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
                .i_go(rd_go), .i_cmd(rd_cmd),
                .o_rd_valid(o_rd_valid), .o_rd_req(o_rd_req), .i_rd_ready(i_rd_ready),
                .i_rd_data(i_rd_data), .i_rd_resp_valid(i_rd_resp_valid),
                .o_rd_resp_ready(o_rd_resp_ready), .i_fifo_full(fifo_full),
                .o_push(push), .o_push_data(push_data)
        );

        gpu_fifo #(.DEPTH(FIFO_DEPTH)) fifo_i (
                .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
                .i_push(push), .i_push_data(push_data), .i_pop(pop),
                .o_full(fifo_full), .o_pop_valid(pop_valid), .o_pop_data(pop_data)
        );

        gpu_dma_writer writer_i (
                .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
                .i_go(wr_go), .i_cmd(wr_cmd),
                .i_pop_valid(pop_valid), .i_pop_data(pop_data), .o_pop(pop),
                .o_wr_valid(o_wr_valid), .o_wr_req(o_wr_req), .i_wr_ready(i_wr_ready),
                .o_done(wr_done)
        );

endmodule

`default_nettype wire

// File: dv/gpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_props
        import gpu_pkg::*;
(
        input wire              i_wire_clock,
        input wire              i_rst_n,
        input wire              i_rd_valid,
        input wire mem_rd_req_t i_rd_req,
        input wire              i_rd_ready,
        input wire              i_wr_valid,
        input wire mem_wr_req_t i_wr_req,
        input wire              i_wr_ready,
        input wire              i_busy
);

        int unsigned fail_count = 0;

        //////////////////////////////////////////////////
        // valid and payload hold until accepted
        //////////////////////////////////////////////////
        a_rd_hold: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                $past(i_rd_valid && !i_rd_ready) |-> i_rd_valid && i_rd_req == $past(i_rd_req))
        else begin
                fail_count++;
                $error("read request changed while stalled");
        end

        a_wr_hold: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                $past(i_wr_valid && !i_wr_ready) |-> i_wr_valid && i_wr_req == $past(i_wr_req))
        else begin
                fail_count++;
                $error("write request changed while stalled");
        end

        // memory traffic only during a copy
        a_rd_busy: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                i_rd_valid |-> i_busy)
        else begin
                fail_count++;
                $error("read request while the sequencer is not busy");
        end

        a_wr_busy: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                i_wr_valid |-> i_busy)
        else begin
                fail_count++;
                $error("write request while the sequencer is not busy");
        end

endmodule

bind gpu_top gpu_props props_i (
        .i_wire_clock(i_wire_clock), .i_rst_n(i_rst_n),
        .i_rd_valid(o_rd_valid), .i_rd_req(o_rd_req), .i_rd_ready(i_rd_ready),
        .i_wr_valid(o_wr_valid), .i_wr_req(o_wr_req), .i_wr_ready(i_wr_ready),
        .i_busy(busy)
);

`default_nettype wire

// File: dv/tb_gpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpu
        import gpu_pkg::*;
();

        localparam int TOTAL_WORDS     = 20 + 40 + 0 + 12;
        localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

        logic              i_wire_clock = 1'b0;
        logic              i_rst_n;
        logic              i_reg_valid;
        reg_req_t          i_reg_req;
        logic              o_reg_rsp_valid;
        logic [DATA_W-1:0] o_reg_rdata;
        logic              o_rd_valid;
        mem_rd_req_t       o_rd_req;
        logic              i_rd_ready;
        logic [DATA_W-1:0] i_rd_data;
        logic              i_rd_resp_valid;
        logic              o_rd_resp_ready;
        logic              o_wr_valid;
        mem_wr_req_t       o_wr_req;
        logic              i_wr_ready;

        // scoreboard state updated 2 ns after each edge
        int unsigned       errors     = 0;
        int unsigned       rd_total   = 0;
        int unsigned       resp_total = 0;
        int unsigned       wr_total   = 0;
        int unsigned       rd_mark    = 0;
        int unsigned       wr_mark    = 0;
        logic [31:0]       src_base   = '0;
        logic [31:0]       dst_base   = '0;
        logic              started    = 1'b0;
        logic              stall      = 1'b0;
        logic              chk_en     = 1'b0;
        logic [31:0]       chk_exp    = '0;
        logic [31:0]       rng        = 32'h864c;
        logic              rd_fire;
        logic              resp_fire;
        logic              wr_fire;
        logic              resp_hold;
        logic [31:0]       rd_addr_s;
        logic [31:0]       rd_pend [$];
        logic [31:0]       exp_rd_addr;
        logic [31:0]       exp_wr_addr;
        logic [31:0]       exp_wr_data;
        logic              exp_resp_ready;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                return y ^ (y << 5);
        endfunction

        // i-th word goes from src + 4i to dst + 4i
        assign exp_rd_addr = src_base + 4 * (rd_total - rd_mark);
        assign exp_wr_addr = dst_base + 4 * (wr_total - wr_mark);
        assign exp_wr_data = xorshift32(src_base + 4 * (wr_total - wr_mark));

        // words accepted from memory and not yet written fill the fifo
        assign exp_resp_ready = (resp_total - wr_total) != FIFO_DEPTH;

        always #20 i_wire_clock = ~i_wire_clock;

        gpu_top dut_i (.*);

        //////////////////////////////////////////////////
        // scoreboard assertions
        //////////////////////////////////////////////////
        a_rd_addr: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                (o_rd_valid && i_rd_ready) |-> o_rd_req.addr == exp_rd_addr)
        else begin
                errors++;
                $display("error o_rd_req.addr: got %h, expected %h",
                         $sampled(o_rd_req.addr), $sampled(exp_rd_addr));
        end

        a_wr_addr: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                (o_wr_valid && i_wr_ready) |-> o_wr_req.addr == exp_wr_addr)
        else begin
                errors++;
                $display("error o_wr_req.addr: got %h, expected %h",
                         $sampled(o_wr_req.addr), $sampled(exp_wr_addr));
        end

        a_wr_data: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                (o_wr_valid && i_wr_ready) |-> o_wr_req.data == exp_wr_data)
        else begin
                errors++;
                $display("error o_wr_req.data: got %h, expected %h",
                         $sampled(o_wr_req.data), $sampled(exp_wr_data));
        end

        a_resp_ready: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                o_rd_resp_ready == exp_resp_ready)
        else begin
                errors++;
                $display("error o_rd_resp_ready: got %h, expected %h",
                         $sampled(o_rd_resp_ready), $sampled(exp_resp_ready));
        end

        // response exactly one cycle after each read
        a_rsp_valid: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                o_reg_rsp_valid == $past(i_reg_valid && !i_reg_req.wr))
        else begin
                errors++;
                $display("error o_reg_rsp_valid: got %h, expected %h",
                         $sampled(o_reg_rsp_valid), !$sampled(o_reg_rsp_valid));
        end

        a_rdata: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                (o_reg_rsp_valid && chk_en) |-> o_reg_rdata == chk_exp)
        else begin
                errors++;
                $display("error o_reg_rdata: got %h, expected %h",
                         $sampled(o_reg_rdata), $sampled(chk_exp));
        end

        a_quiet: assert property (@(posedge i_wire_clock) disable iff (!i_rst_n)
                !started |-> !o_rd_valid && !o_wr_valid)
        else begin
                errors++;
                $display("memory request seen before the first start command");
        end

        //////////////////////////////////////////////////
        // memory model
        //////////////////////////////////////////////////
        initial begin
                i_rd_ready      = 1'b0;
                i_rd_data       = '0;
                i_rd_resp_valid = 1'b0;
                i_wr_ready      = 1'b0;
                forever begin
                        // handshakes taken mid cycle
                        @(negedge i_wire_clock);
                        rd_fire   = i_rst_n && o_rd_valid && i_rd_ready;
                        resp_fire = i_rst_n && i_rd_resp_valid && o_rd_resp_ready;
                        wr_fire   = i_rst_n && o_wr_valid && i_wr_ready;
                        rd_addr_s = o_rd_req.addr;
                        @(posedge i_wire_clock);
                        #2;
                        resp_hold = i_rd_resp_valid && !resp_fire;
                        if (resp_fire) begin
                                void'(rd_pend.pop_front());
                                resp_total++;
                        end
                        if (rd_fire) begin
                                rd_pend.push_back(rd_addr_s);
                                rd_total++;
                        end
                        if (wr_fire) begin
                                wr_total++;
                        end
                        rng        = xorshift32(rng);
                        i_rd_ready = !stall || (rng[1:0] != 2'b00);
                        // slower writes let the fifo fill up
                        i_wr_ready = !stall || rng[9];
                        if (rd_pend.size() != 0 && (resp_hold || !stall || rng[5:4] != 2'b00)) begin
                                i_rd_resp_valid = 1'b1;
                                i_rd_data       = xorshift32(rd_pend[0]);
                        end else begin
                                i_rd_resp_valid = 1'b0;
                        end
                end
        end

        //////////////////////////////////////////////////
        // host tasks
        //////////////////////////////////////////////////
        task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
                i_reg_valid = 1'b1;
                i_reg_req   = '{wr: 1'b1, addr: addr, wdata: data};
                @(posedge i_wire_clock);
                #2;
                i_reg_valid = 1'b0;
        endtask

        task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
                i_reg_valid = 1'b1;
                i_reg_req   = '{wr: 1'b0, addr: addr, wdata: '0};
                @(posedge i_wire_clock);
                #2;
                i_reg_valid = 1'b0;
                @(posedge i_wire_clock);
                #2;
                data = o_reg_rdata;
        endtask

        task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp);
                logic [31:0] rdata;
                chk_exp = exp;
                chk_en  = 1'b1;
                reg_read(addr, rdata);
                chk_en = 1'b0;
        endtask

        task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                                  input logic [15:0] len);
                src_base = src;
                dst_base = dst;
                rd_mark  = rd_total;
                wr_mark  = wr_total;
                started  = 1'b1;
                reg_write(REG_SRC, src);
                reg_write(REG_DST, dst);
                reg_write(REG_LEN, {16'h0, len});
                reg_write(REG_CTRL, 32'h1);
        endtask

        // poll until done = 1 and busy = 0
        task automatic wait_done();
                logic [31:0] status;
                status = '0;
                while (status[1:0] != 2'b10) begin
                        reg_read(REG_STATUS, status);
                end
        endtask

        task automatic check_count(input string what, input int unsigned got,
                                   input int unsigned exp);
                assert (got == exp)
                else begin
                        errors++;
                        $display("error %s: got %h, expected %h", what, got, exp);
                end
        endtask

        task automatic check_copy(input int unsigned len);
                check_count("read count", rd_total - rd_mark, len);
                check_count("write count", wr_total - wr_mark, len);
                reg_check(REG_STATUS, 32'h2);
        endtask

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge i_wire_clock);
                $display("timeout after %0d cycles, the copy engine stopped making progress",
                         WATCHDOG_CYCLES);
                $display("** FAIL **");
                $finish;
        end

        //////////////////////////////////////////////////
        // test sequence
        //////////////////////////////////////////////////
        initial begin
                i_rst_n     = 1'b0;
                i_reg_valid = 1'b0;
                i_reg_req   = '0;
                repeat (16) @(posedge i_wire_clock);
                #2;
                i_rst_n = 1'b1;
                @(posedge i_wire_clock);
                #2;
                reg_check(REG_STATUS, 32'h0);

                // register readback
                reg_write(REG_SRC, 32'h1234_5678);
                reg_check(REG_SRC, 32'h1234_5678);
                reg_write(REG_DST, 32'hA5A5_0F00);
                reg_check(REG_DST, 32'hA5A5_0F00);
                reg_write(REG_LEN, 32'h0000_0ABC);
                reg_check(REG_LEN, 32'h0000_0ABC);

                // plain copy with busy checked right after the start
                start_copy(32'h0000_1000, 32'h0008_0000, 16'd20);
                reg_check(REG_STATUS, 32'h1);
                wait_done();
                check_copy(20);

                // random stalls on every channel
                stall = 1'b1;
                start_copy(32'h0010_0400, 32'h0020_0800, 16'd40);
                wait_done();
                stall = 1'b0;
                check_copy(40);

                start_copy(32'h0000_3000, 32'h0000_4000, 16'd0);
                wait_done();
                check_copy(0);

                // start while busy is dropped
                start_copy(32'h0000_5000, 32'h0000_6000, 16'd12);
                reg_write(REG_LEN, 32'h5);
                reg_write(REG_CTRL, 32'h1);
                wait_done();
                check_copy(12);

                $display("tb_gpu: %0d check errors, %0d protocol errors",
                         errors, dut_i.props_i.fail_count);
                if (errors == 0 && dut_i.props_i.fail_count == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: gpu_copy.f
rtl/gpu_pkg.sv
rtl/gpu_regs.sv
rtl/gpu_memcpy.sv
rtl/gpu_dma_reader.sv
rtl/gpu_fifo.sv
rtl/gpu_dma_writer.sv
rtl/gpu_top.sv
dv/gpu_props.sv
dv/tb_gpu.sv

// File: run.sh
#!/bin/sh
# build and run the copy engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_gpu -f gpu_copy.f -o sim_gpu &&
        ./obj_dir/sim_gpu +verilator+error+limit+100 | tee /dev/stderr |
        grep -q -F "** PASS **" &&
        echo "simulation passed" ||
        { echo "simulation failed"; exit 1; }
